/* hw/rv_pkg.sv */
// Shared widths, RV32I encodings and the stage type of the multi-cycle core
// Memory is 1024 words, so byte addresses above 0xFFC wrap

package rv_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int MEM_AW = 10;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_idx_t;
  typedef logic [MEM_AW-1:0] mem_addr_t;  // Byte address bits 11:2
  typedef logic [2:0]        funct3_t;

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_t;

  // ALU functions
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SL   = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam funct3_t F3_W    = 3'b010;  // Word load/store

  localparam int SUB_BIT = 30;  // Also selects arithmetic right shift

  typedef enum logic [2:0] {ST_T0, ST_T1, ST_T2, ST_T3, ST_T4} stage_t;

  localparam word_t PC_STEP = 32'd4;

endpackage

/* hw/rv_ifaces.sv */
// Buses between the core blocks; all return paths are combinational
`timescale 1ns/1ns

interface alu_if;
  import rv_pkg::*;
  word_t    a, b, res;
  funct3_t  op;
  logic     sub, arith;
  reg_idx_t shamt;
  logic     eq, ge, geu;
  modport ctl (output a, b, op, sub, arith, shamt, input res, eq, ge, geu);
  modport alu (input a, b, op, sub, arith, shamt, output res, eq, ge, geu);
endinterface

interface rf_if;
  import rv_pkg::*;
  reg_idx_t rs1, rs2, rd;
  logic     we;
  word_t    wdata, rs1_data, rs2_data;
  modport ctl (output rs1, rs2, rd, we, wdata, input rs1_data, rs2_data);
  modport rf (input rs1, rs2, rd, we, wdata, output rs1_data, rs2_data);
endinterface

interface mem_if;
  import rv_pkg::*;
  mem_addr_t raddr, waddr;
  logic      we;
  word_t     wdata, rdata;
  modport ctl (output raddr, waddr, we, wdata, input rdata);
  modport mem (input raddr, waddr, we, wdata, output rdata);
endinterface

interface instr_if;
  import rv_pkg::*;
  word_t    ir;
  opcode_t  opcode;
  funct3_t  funct3;
  reg_idx_t rd, rs1, rs2;
  word_t    imm_i, imm_s, imm_b, imm_u, imm_j;
  modport ctl (output ir, input opcode, funct3, rd, rs1, rs2, imm_i, imm_s, imm_b, imm_u, imm_j);
  modport dec (input ir, output opcode, funct3, rd, rs1, rs2, imm_i, imm_s, imm_b, imm_u, imm_j);
endinterface

/* hw/rv_alu.sv */
// Combinational ALU; sub only affects the adder
// Compare flags always look at a and b, whatever op is
`timescale 1ns/1ns

module rv_alu (
  alu_if.alu bus
);
  import rv_pkg::*;

  word_t b_in;
  word_t sum;
  word_t carry;  // Carry into each bit

  assign b_in = bus.sub ? ~bus.b : bus.b;
  assign carry[0] = bus.sub;  // +1 completes the two's complement

  for (genvar i = 0; i < XLEN; i++) begin : g_rca
    assign sum[i] = bus.a[i] ^ b_in[i] ^ carry[i];
    if (i < XLEN - 1) begin : g_carry
      assign carry[i+1] = (bus.a[i] & b_in[i]) | ((bus.a[i] ^ b_in[i]) & carry[i]);
    end
  end

  assign bus.eq  = bus.a == bus.b;
  assign bus.ge  = $signed(bus.a) >= $signed(bus.b);
  assign bus.geu = bus.a >= bus.b;

  always_comb begin
    case (bus.op)
      F3_ADD:  bus.res = sum;
      F3_SL:   bus.res = bus.a << bus.shamt;
      F3_SLT:  bus.res = {{(XLEN-1){1'b0}}, ~bus.ge};
      F3_SLTU: bus.res = {{(XLEN-1){1'b0}}, ~bus.geu};
      F3_XOR:  bus.res = bus.a ^ bus.b;
      F3_SR: begin
        if (bus.arith) bus.res = $signed(bus.a) >>> bus.shamt;
        else bus.res = bus.a >> bus.shamt;
      end
      F3_OR:   bus.res = bus.a | bus.b;
      F3_AND:  bus.res = bus.a & bus.b;
      default: bus.res = sum;
    endcase
  end

endmodule

/* hw/rv_regfile.sv */
// 32 x 32 register file, two async reads and one write per clock
// x0 reads zero because writes to it are dropped
`timescale 1ns/1ns

module rv_regfile (
  input logic clk,
  rf_if.rf    bus
);
  import rv_pkg::*;

  word_t regs [0:(1 << REG_AW) - 1];

  initial begin
    for (int i = 0; i < (1 << REG_AW); i++) begin
      regs[i] = '0;
    end
  end

  assign bus.rs1_data = regs[bus.rs1];
  assign bus.rs2_data = regs[bus.rs2];

  always @(posedge clk) begin
    if (bus.we && (bus.rd != '0)) begin
      regs[bus.rd] <= bus.wdata;
    end
  end

endmodule

/* hw/rv_decode.sv */
// Instruction field split and immediate formation, purely combinational
// Fields are valid for any ir; control decides which ones matter
`timescale 1ns/1ns

module rv_decode (
  instr_if.dec bus
);
  import rv_pkg::*;

  word_t ir;

  assign ir = bus.ir;

  assign bus.opcode = opcode_t'(ir[6:0]);
  assign bus.rd     = ir[11:7];
  assign bus.funct3 = ir[14:12];
  assign bus.rs1    = ir[19:15];
  assign bus.rs2    = ir[24:20];  // Also shamt for immediate shifts

  // I-type, loads and JALR
  assign bus.imm_i = {{20{ir[31]}}, ir[31:20]};

  // S-type, split across funct7 and rd
  assign bus.imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};

  assign bus.imm_b = {
    {19{ir[31]}},
    ir[31],
    ir[7],
    ir[30:25],
    ir[11:8],
    1'b0
  };

  assign bus.imm_u = {ir[31:12], 12'b0};

  assign bus.imm_j = {
    {11{ir[31]}},
    ir[31],
    ir[19:12],
    ir[20],
    ir[30:21],
    1'b0
  };

endmodule

/* hw/rv_control.sv */
// Stage FSM of the core; one instruction at a time, T0 fetches from pc
// Only word loads/stores; other funct3 values and unknown opcodes refetch pc
`timescale 1ns/1ns

module rv_control (
  input  logic          clk,
  input  logic          rstn,
  instr_if.ctl          ins,
  alu_if.ctl            alu,
  rf_if.ctl             rf,
  mem_if.ctl            mem,
  output rv_pkg::word_t pc
);
  import rv_pkg::*;

  stage_t stage;
  word_t  target;  // Branch target from T2
  logic   taken;
  word_t  br_next;

  always_comb begin
    case (ins.funct3)
      F3_BEQ:  taken = alu.eq;
      F3_BNE:  taken = !alu.eq;
      F3_BLT:  taken = !alu.ge;
      F3_BGE:  taken = alu.ge;
      F3_BLTU: taken = !alu.geu;
      F3_BGEU: taken = alu.geu;
      default: taken = 1'b0;
    endcase
  end

  assign br_next = taken ? target : rf.wdata;  // wdata holds pc + 4

  always_ff @(posedge clk) begin
    if (rstn) begin
      stage     <= ST_T0;
      ins.ir    <= '0;
      pc        <= '0;
      mem.raddr <= '0;
      mem.we    <= 1'b0;
      rf.we     <= 1'b0;
    end else begin
      case (stage)
        ST_T0: begin
          ins.ir  <= mem.rdata;
          alu.a   <= pc;
          alu.b   <= PC_STEP;
          alu.op  <= F3_ADD;
          alu.sub <= 1'b0;
          rf.we   <= 1'b0;
          mem.we  <= 1'b0;
          stage   <= ST_T1;
        end
        ST_T1: begin
          stage <= ST_T2;
          case (ins.opcode)
            OP_REG, OP_IMM: begin
              rf.rs1 <= ins.rs1;
              rf.rs2 <= ins.rs2;
              pc     <= alu.res;
            end
            OP_LOAD, OP_STORE: begin
              rf.rs1 <= ins.rs1;
              if (ins.funct3 == F3_W) pc <= alu.res;
              else stage <= ST_T0;
            end
            OP_BRANCH: begin
              rf.wdata <= alu.res;
              alu.b    <= ins.imm_b;
              rf.rs1   <= ins.rs1;
              rf.rs2   <= ins.rs2;
            end
            OP_LUI: begin
              rf.we     <= 1'b1;
              rf.rd     <= ins.rd;
              rf.wdata  <= ins.imm_u;
              pc        <= alu.res;
              mem.raddr <= alu.res[MEM_AW+1:2];
              stage     <= ST_T0;
            end
            OP_AUIPC: begin
              pc        <= alu.res;
              mem.raddr <= alu.res[MEM_AW+1:2];
              alu.b     <= ins.imm_u;  // alu.a still holds the old pc
            end
            OP_JAL, OP_JALR: begin
              rf.we    <= 1'b1;
              rf.rd    <= ins.rd;
              rf.wdata <= alu.res;  // Link value
              rf.rs1   <= ins.rs1;
              alu.b    <= ins.imm_j;
            end
            default: stage <= ST_T0;
          endcase
        end
        ST_T2: begin
          stage <= ST_T3;
          case (ins.opcode)
            OP_REG, OP_IMM: begin
              alu.a     <= rf.rs1_data;
              alu.op    <= ins.funct3;
              alu.arith <= ins.ir[SUB_BIT];
              if (ins.opcode == OP_REG) begin
                alu.b     <= rf.rs2_data;
                alu.sub   <= ins.ir[SUB_BIT];
                alu.shamt <= rf.rs2_data[REG_AW-1:0];
              end else begin
                alu.b     <= ins.imm_i;
                alu.shamt <= ins.rs2;
              end
            end
            OP_LOAD, OP_STORE: begin
              alu.a <= rf.rs1_data;
              alu.b <= (ins.opcode == OP_STORE) ? ins.imm_s : ins.imm_i;
            end
            OP_BRANCH: begin
              target <= alu.res;
              alu.a  <= rf.rs1_data;
              alu.b  <= rf.rs2_data;
            end
            OP_AUIPC: begin
              rf.we    <= 1'b1;
              rf.rd    <= ins.rd;
              rf.wdata <= alu.res;
              stage    <= ST_T0;
            end
            OP_JAL: begin
              rf.we     <= 1'b0;
              pc        <= alu.res;
              mem.raddr <= alu.res[MEM_AW+1:2];
              stage     <= ST_T0;
            end
            OP_JALR: begin
              rf.we <= 1'b0;
              alu.a <= rf.rs1_data;  // Read before the link write lands
              alu.b <= ins.imm_i;
            end
            default: stage <= ST_T0;
          endcase
        end
        ST_T3: begin
          stage <= ST_T0;
          case (ins.opcode)
            OP_REG, OP_IMM: begin
              rf.we     <= 1'b1;
              rf.rd     <= ins.rd;
              rf.wdata  <= alu.res;
              mem.raddr <= pc[MEM_AW+1:2];
            end
            OP_LOAD: begin
              mem.raddr <= alu.res[MEM_AW+1:2];
              stage     <= ST_T4;
            end
            OP_STORE: begin
              mem.waddr <= alu.res[MEM_AW+1:2];
              rf.rs2    <= ins.rs2;
              stage     <= ST_T4;
            end
            OP_BRANCH: begin
              pc        <= br_next;
              mem.raddr <= br_next[MEM_AW+1:2];
            end
            OP_JALR: begin
              pc        <= {alu.res[XLEN-1:1], 1'b0};
              mem.raddr <= alu.res[MEM_AW+1:2];
            end
            default: ;
          endcase
        end
        ST_T4: begin
          stage     <= ST_T0;
          mem.raddr <= pc[MEM_AW+1:2];
          if (ins.opcode == OP_LOAD) begin
            rf.we    <= 1'b1;
            rf.rd    <= ins.rd;
            rf.wdata <= mem.rdata;
          end else begin
            mem.we    <= 1'b1;  // Lands during the next T0
            mem.wdata <= rf.rs2_data;
          end
        end
        default: stage <= ST_T0;
      endcase
    end
  end

endmodule

/* hw/rv_mem.sv */
// Unified instruction and data memory, 1024 words, word access only
// Contents come from sim/program.hex, relative to the run directory
`timescale 1ns/1ns

module rv_mem (
  input logic clk,
  mem_if.mem  bus
);
  import rv_pkg::*;

  word_t mem [0:(1 << MEM_AW) - 1];

  initial begin
    $readmemh("sim/program.hex", mem);
  end

  assign bus.rdata = mem[bus.raddr];  // Async read

  always @(posedge clk) begin
    if (bus.we) begin
      mem[bus.waddr] <= bus.wdata;
    end
  end

endmodule

/* hw/rv_core.sv */
// Multi-cycle RV32I core with a retire trace taken from the register write port
// retire_we also pulses for writes to x0
`timescale 1ns/1ns

module rv_core (
  input  logic             clk,
  input  logic             rstn,
  output logic             retire_we,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::word_t    retire_data,
  output rv_pkg::word_t    pc
);

  instr_if ins_bus ();
  alu_if   alu_bus ();
  rf_if    rf_bus ();
  mem_if   mem_bus ();

  rv_control u_control (
    .clk  (clk),
    .rstn (rstn),
    .ins  (ins_bus),
    .alu  (alu_bus),
    .rf   (rf_bus),
    .mem  (mem_bus),
    .pc   (pc)
  );

  rv_decode  u_decode  (.bus(ins_bus));
  rv_alu     u_alu     (.bus(alu_bus));
  rv_regfile u_regfile (.clk(clk), .bus(rf_bus));
  rv_mem     u_mem     (.clk(clk), .bus(mem_bus));

  assign retire_we   = rf_bus.we;
  assign retire_rd   = rf_bus.rd;
  assign retire_data = rf_bus.wdata;

endmodule

/* sim/rv_core_sva.sv */
// Bound into rv_control; sampled on the rising clock, rstn is active high
`timescale 1ns/1ns

module rv_core_sva (
  input logic           clk,
  input logic           rstn,
  input rv_pkg::stage_t stage,
  input logic           retire_we,
  input logic           mem_we,
  input rv_pkg::word_t  pc
);
  import rv_pkg::*;

  int n_err = 0;

  // Previous edge saw reset, so the core must be idle now
  a_reset_idle: assert property (@(posedge clk)
    $past(rstn) |-> (stage == ST_T0) && (pc == '0) && !retire_we && !mem_we)
    else begin
      n_err++;
      $error("Core not idle during reset or in the first cycle after it");
    end

  a_retire_gap: assert property (@(posedge clk) retire_we |=> !retire_we)
    else begin
      n_err++;
      $error("Register write enable high on two cycles in a row");
    end

  a_store_pulse: assert property (@(posedge clk) mem_we |=> !mem_we)  // One-cycle store
    else begin
      n_err++;
      $error("Memory write enable high for more than one cycle");
    end

  a_pc_align: assert property (@(posedge clk) disable iff (rstn) pc[1:0] == 2'b00)
    else begin
      n_err++;
      $error("pc is not word aligned");
    end

endmodule

bind rv_control rv_core_sva u_sva (
  .clk       (clk),
  .rstn      (rstn),
  .stage     (stage),
  .retire_we (rf.we),
  .mem_we    (mem.we),
  .pc        (pc)
);

/* sim/tb_rv_core.sv */
// Runs sim/program.hex on rv_core and checks every register write in program order
// Expected values follow the RV32I rules for that fixed program; run from the project root
`timescale 1ns/1ns

module tb_rv_core;

  localparam int          RETIRE_TIMEOUT = 50;
  localparam logic [31:0] A = 32'd100;          // x1
  localparam logic [31:0] B = 32'hFFFF_FFF9;    // x2, -7
  localparam logic [31:0] U = 32'h0001_2345;    // LUI immediate

  logic        clk;
  logic        rstn;
  logic        retire_we;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;
  logic [31:0] pc;

  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];
  logic [31:0] exp_pc [$];
  string       exp_name [$];

  int n_run;
  int n_fail;

  rv_core u_dut (
    .clk         (clk),
    .rstn        (rstn),
    .retire_we   (retire_we),
    .retire_rd   (retire_rd),
    .retire_data (retire_data),
    .pc          (pc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic add_retire(input logic [4:0] rd, input logic [31:0] val,
                            input logic [31:0] at_pc, input string name);
    exp_rd.push_back(rd);
    exp_val.push_back(val);
    exp_pc.push_back(at_pc);
    exp_name.push_back(name);
  endtask

  // pc already points past the instruction, except in the link cycle of a jump
  task automatic build_expected();
    add_retire(5'd1, A, 32'h04, "addi");
    add_retire(5'd2, B, 32'h08, "addi_neg");
    add_retire(5'd3, A + B, 32'h0C, "add");
    add_retire(5'd4, B - A, 32'h10, "sub");
    add_retire(5'd5, A ^ B, 32'h14, "xor");
    add_retire(5'd6, A | B, 32'h18, "or");
    add_retire(5'd7, A & B, 32'h1C, "and");
    add_retire(5'd8, ($signed(B) < $signed(A)) ? 32'd1 : 32'd0, 32'h20, "slt");
    add_retire(5'd9, (B < A) ? 32'd1 : 32'd0, 32'h24, "sltu");
    add_retire(5'd10, 32'd3, 32'h28, "addi_shamt");
    add_retire(5'd11, B << 3, 32'h2C, "sll");
    add_retire(5'd12, B >> 3, 32'h30, "srl");
    add_retire(5'd13, $signed(B) >>> 3, 32'h34, "sra");
    add_retire(5'd0, 32'd55, 32'h38, "x0_write");  // Port still pulses
    add_retire(5'd5, 32'd0, 32'h3C, "x0_read");
    add_retire(5'd14, U << 12, 32'h40, "lui");
    add_retire(5'd15, (32'd1 << 12) + 32'h40, 32'h44, "auipc");
    add_retire(5'd17, 32'h51, 32'h54, "beq");
    add_retire(5'd17, 32'h52, 32'h64, "bne");
    add_retire(5'd17, 32'h53, 32'h74, "blt");
    add_retire(5'd17, 32'h54, 32'h84, "bge");
    add_retire(5'd17, 32'h55, 32'h94, "bltu");
    add_retire(5'd17, 32'h56, 32'hA4, "bgeu");
    add_retire(5'd20, 32'hA4 + 32'd4, 32'hA4, "jal_link");
    add_retire(5'd21, 32'hC1, 32'hB0 + 32'd4, "jal_target");
    add_retire(5'd22, 32'hB4 + 32'd4, 32'hB4, "jalr_link");
    add_retire(5'd23, 32'hD1, ((32'hA8 + 32'h19) & 32'hFFFF_FFFE) + 32'd4, "jalr_target");
    add_retire(5'd24, 32'h210, 32'hC8, "sw_base");
    add_retire(5'd25, U << 12, 32'hD0, "lw");
  endtask

  // Retire signals are sampled mid-cycle
  task automatic wait_retire(output bit seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < RETIRE_TIMEOUT) begin
      @(negedge clk);
      if (retire_we === 1'b1) seen = 1'b1;
      cycles++;
    end
  endtask

  initial begin
    bit seen;
    bit ok;
    int sva_errors;
    rstn = 1'b1;
    n_run = 0;
    n_fail = 0;
    build_expected();
    repeat (16) @(posedge clk);
    #1 rstn = 1'b0;

    for (int i = 0; i < exp_name.size(); i++) begin
      wait_retire(seen);
      n_run++;
      if (!seen) begin
        $display("Timeout: no register write for test %s within %0d cycles",
                 exp_name[i], RETIRE_TIMEOUT);
        n_fail++;
        break;
      end
      ok = 1'b1;
      assert (retire_rd === exp_rd[i]) else begin
        $display("[FAIL] %s rd expected %0d actual %0d", exp_name[i], exp_rd[i], retire_rd);
        ok = 1'b0;
      end
      assert (retire_data === exp_val[i]) else begin
        $display("[FAIL] %s data expected %h actual %h", exp_name[i], exp_val[i], retire_data);
        ok = 1'b0;
      end
      assert (pc === exp_pc[i]) else begin
        $display("[FAIL] %s pc expected %h actual %h", exp_name[i], exp_pc[i], pc);
        ok = 1'b0;
      end
      if (ok) $display("[PASS] %s", exp_name[i]);
      else n_fail++;
    end

    sva_errors = u_dut.u_control.u_sva.n_err;
    if (sva_errors != 0) begin
      $display("Bound assertions on the core failed %0d times", sva_errors);
    end

    $display("Tests: %0d run, %0d passed, %0d failed", n_run, n_run - n_fail, n_fail);
    if (n_fail == 0 && sva_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sim/program.hex */
// One 32-bit instruction word per line, from byte address 0x00 upward
// Second column is the byte address and the assembly
06400093 // 00 addi x1, x0, 100
FF900113 // 04 addi x2, x0, -7
002081B3 // 08 add  x3, x1, x2
40110233 // 0C sub  x4, x2, x1
0020C2B3 // 10 xor  x5, x1, x2
0020E333 // 14 or   x6, x1, x2
0020F3B3 // 18 and  x7, x1, x2
00112433 // 1C slt  x8, x2, x1
001134B3 // 20 sltu x9, x2, x1
00300513 // 24 addi x10, x0, 3
00A115B3 // 28 sll  x11, x2, x10
00A15633 // 2C srl  x12, x2, x10
40A156B3 // 30 sra  x13, x2, x10
03700013 // 34 addi x0, x0, 55
000002B3 // 38 add  x5, x0, x0
12345737 // 3C lui  x14, 0x12345
00001797 // 40 auipc x15, 0x1
00108463 // 44 beq  x1, x1, +8 taken
7FF00813 // 48 addi x16, x0, 0x7ff skipped
00208463 // 4C beq  x1, x2, +8 not taken
05100893 // 50 addi x17, x0, 0x51
00209463 // 54 bne  x1, x2, +8 taken
7FF00813 // 58 skipped
00109463 // 5C bne  x1, x1, +8 not taken
05200893 // 60 addi x17, x0, 0x52
00114463 // 64 blt  x2, x1, +8 taken
7FF00813 // 68 skipped
0020C463 // 6C blt  x1, x2, +8 not taken
05300893 // 70 addi x17, x0, 0x53
0020D463 // 74 bge  x1, x2, +8 taken
7FF00813 // 78 skipped
00115463 // 7C bge  x2, x1, +8 not taken
05400893 // 80 addi x17, x0, 0x54
0020E463 // 84 bltu x1, x2, +8 taken
7FF00813 // 88 skipped
00116463 // 8C bltu x2, x1, +8 not taken
05500893 // 90 addi x17, x0, 0x55
00117463 // 94 bgeu x2, x1, +8 taken
7FF00813 // 98 skipped
0020F463 // 9C bgeu x1, x2, +8 not taken
05600893 // A0 addi x17, x0, 0x56
00C00A6F // A4 jal  x20, +12
7FF00813 // A8 skipped
7FF00813 // AC skipped
0C100A93 // B0 addi x21, x0, 0xc1
019A0B67 // B4 jalr x22, 0x19(x20) to 0xc0
7FF00813 // B8 skipped
7FF00813 // BC skipped
0D100B93 // C0 addi x23, x0, 0xd1
21000C13 // C4 addi x24, x0, 0x210
FEEC2823 // C8 sw   x14, -16(x24)
FF0C2C83 // CC lw   x25, -16(x24)
0000006F // D0 jal  x0, 0

/* rv_core.f */
hw/rv_pkg.sv
hw/rv_ifaces.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_control.sv
hw/rv_mem.sv
hw/rv_core.sv
sim/rv_core_sva.sv
sim/tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Verilator build and run from the project root; fails on the fail message or a missing result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_core -f rv_core.f \
  && ./obj_dir/Vtb_rv_core > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
! grep -q "RESULT: FAIL" sim.log && grep -q "RESULT: PASS" sim.log || exit 1
